/* design/isp_pkg.sv */
package isp_pkg;

    ////////////////////////////////////////////////////////////
    // design constants
    ////////////////////////////////////////////////////////////

    localparam int pix_width = 10;
    // pixels per line, sizes the line buffers
    localparam int img_width = 16;

    typedef logic [pix_width-1:0] pixel_t;

    // one pixel strobe with its flags
    typedef struct packed {
        logic   valid;
        logic   sof;
        logic   eol;
        pixel_t data;
    } pixel_beat_t;

    // 3x3 neighborhood, row 0 oldest line, column 2 newest pixel
    typedef struct packed {
        logic   valid;
        logic   sof;
        logic   eol;
        logic   complete;
        pixel_t p00, p01, p02;
        pixel_t p10, p11, p12;
        pixel_t p20, p21, p22;
    } window_t;

    ////////////////////////////////////////////////////////////
    // debug tap selection
    ////////////////////////////////////////////////////////////

    typedef logic [1:0] tap_t;

    localparam tap_t tap_gauss = 2'd0;
    localparam tap_t tap_raw   = 2'd1;
    localparam tap_t tap_dpc   = 2'd2;

endpackage

/* design/window_3x3.sv */
`timescale 1ns/1ps

module window_3x3
(
    input  logic                 pixel_clk,
    input  logic                 reset,
    input  isp_pkg::pixel_beat_t in,
    output isp_pkg::window_t     win
);

    // two previous lines, line_0 is the older one
    isp_pkg::pixel_t line_0 [isp_pkg::img_width];
    isp_pkg::pixel_t line_1 [isp_pkg::img_width];

    logic [$clog2(isp_pkg::img_width)-1:0] col_cnt;
    logic [$clog2(isp_pkg::img_width)-1:0] cur_col;
    // saturates at 2, enough for the complete test
    logic [1:0] row_cnt;
    logic [1:0] cur_row;

    isp_pkg::pixel_t top_pix;
    isp_pkg::pixel_t mid_pix;

    ////////////////////////////////////////////////////////////
    // position of the incoming pixel
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        // sof restarts both counters on the same beat
        cur_col = in.sof ? '0 : col_cnt;
        cur_row = in.sof ? 2'd0 : row_cnt;
        top_pix = line_0[cur_col];
        mid_pix = line_1[cur_col];
    end

    ////////////////////////////////////////////////////////////
    // line buffers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pixel_clk)
    begin
        if (in.valid)
        begin
            // each line moves up one row
            line_0[cur_col] <= mid_pix;
            line_1[cur_col] <= in.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // counters and window taps
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pixel_clk)
    begin
        if (reset)
        begin
            col_cnt   <= '0;
            row_cnt   <= 2'd0;
            win.valid <= 1'b0;
        end
        else
        begin
            win.valid <= in.valid;
            if (in.valid)
            begin
                if (in.eol)
                begin
                    col_cnt <= '0;
                    row_cnt <= (cur_row == 2'd2) ? cur_row : cur_row + 2'd1;
                end
                else
                begin
                    col_cnt <= cur_col + 1'b1;
                    row_cnt <= cur_row;
                end
            end
        end

        if (in.valid)
        begin
            win.sof      <= in.sof;
            win.eol      <= in.eol;
            win.complete <= (cur_row == 2'd2) && (cur_col >= 2);
            // shift columns left, newest column enters at 2
            win.p00 <= win.p01;
            win.p01 <= win.p02;
            win.p02 <= top_pix;
            win.p10 <= win.p11;
            win.p11 <= win.p12;
            win.p12 <= mid_pix;
            win.p20 <= win.p21;
            win.p21 <= win.p22;
            win.p22 <= in.data;
        end
    end

endmodule

/* design/dead_pixel_corrector.sv */
`timescale 1ns/1ps

module dead_pixel_corrector
(
    input  logic                 pixel_clk,
    input  logic                 reset,
    input  logic                 enable,
    input  isp_pkg::pixel_t      threshold,
    input  isp_pkg::window_t     win,
    output isp_pkg::pixel_beat_t out
);

    isp_pkg::pixel_t nb [8];
    logic hot;
    logic cold;
    logic [isp_pkg::pix_width+1:0] cross_sum;
    isp_pkg::pixel_t next_data;

    always_comb
    begin
        nb[0] = win.p00;
        nb[1] = win.p01;
        nb[2] = win.p02;
        nb[3] = win.p10;
        nb[4] = win.p12;
        nb[5] = win.p20;
        nb[6] = win.p21;
        nb[7] = win.p22;

        // center must stand out from every neighbor
        hot  = 1'b1;
        cold = 1'b1;
        for (int i = 0; i < 8; i++)
        begin
            if ({1'b0, win.p11} <= {1'b0, nb[i]} + {1'b0, threshold})
                hot = 1'b0;
            if ({1'b0, nb[i]} <= {1'b0, win.p11} + {1'b0, threshold})
                cold = 1'b0;
        end

        // up, down, left, right
        cross_sum = win.p01 + win.p21 + win.p10 + win.p12;

        if (!win.complete)
            next_data = win.p22;
        else if (enable && (hot || cold))
            next_data = cross_sum[isp_pkg::pix_width+1:2];
        else
            next_data = win.p11;
    end

    always_ff @(posedge pixel_clk)
    begin
        if (reset)
            out.valid <= 1'b0;
        else
            out.valid <= win.valid;

        out.sof  <= win.sof;
        out.eol  <= win.eol;
        out.data <= next_data;
    end

endmodule

/* design/gauss_blur.sv */
`timescale 1ns/1ps

module gauss_blur
(
    input  logic                 pixel_clk,
    input  logic                 reset,
    input  logic                 enable,
    input  isp_pkg::window_t     win,
    output isp_pkg::pixel_beat_t out
);

    logic [isp_pkg::pix_width+1:0] edge_sum;
    logic [isp_pkg::pix_width+1:0] corner_sum;
    // 16 x max pixel fits in four extra bits
    logic [isp_pkg::pix_width+3:0] weighted_sum;
    isp_pkg::pixel_t next_data;

    always_comb
    begin
        edge_sum     = win.p01 + win.p10 + win.p12 + win.p21;
        corner_sum   = win.p00 + win.p02 + win.p20 + win.p22;
        // weights 4 / 2 / 1
        weighted_sum = {win.p11, 2'b00} + {edge_sum, 1'b0} + corner_sum;

        if (!win.complete)
            next_data = win.p22;
        else if (enable)
            next_data = weighted_sum[isp_pkg::pix_width+3:4];
        else
            next_data = win.p11;
    end

    always_ff @(posedge pixel_clk)
    begin
        if (reset)
            out.valid <= 1'b0;
        else
            out.valid <= win.valid;

        out.sof  <= win.sof;
        out.eol  <= win.eol;
        out.data <= next_data;
    end

endmodule

/* design/isp_pipeline.sv */
`timescale 1ns/1ps

module isp_pipeline
(
    input  logic                 pixel_clk,
    input  logic                 reset,
    input  isp_pkg::pixel_beat_t in,
    input  logic                 dpc_en,
    input  isp_pkg::pixel_t      dpc_threshold,
    input  logic                 blur_en,
    input  isp_pkg::tap_t        debug_sel,
    output isp_pkg::pixel_beat_t out
);

    isp_pkg::pixel_beat_t in_q;
    isp_pkg::window_t     dpc_win;
    isp_pkg::pixel_beat_t dpc_beat;
    isp_pkg::window_t     blur_win;
    isp_pkg::pixel_beat_t blur_beat;

    logic            dpc_en_q;
    logic            blur_en_q;
    isp_pkg::pixel_t dpc_threshold_q;
    isp_pkg::tap_t   debug_sel_q;

    ////////////////////////////////////////////////////////////
    // input and control registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pixel_clk)
    begin
        in_q            <= in;
        dpc_threshold_q <= dpc_threshold;
        if (reset)
        begin
            in_q.valid  <= 1'b0;
            dpc_en_q    <= 1'b0;
            blur_en_q   <= 1'b0;
            debug_sel_q <= isp_pkg::tap_gauss;
        end
        else
        begin
            dpc_en_q    <= dpc_en;
            blur_en_q   <= blur_en;
            debug_sel_q <= debug_sel;
        end
    end

    ////////////////////////////////////////////////////////////
    // dead pixel stage, then blur stage
    ////////////////////////////////////////////////////////////

    window_3x3 u_dpc_window (.pixel_clk(pixel_clk), .reset(reset), .in(in_q), .win(dpc_win));

    dead_pixel_corrector u_dpc
    (
        .pixel_clk (pixel_clk),
        .reset     (reset),
        .enable    (dpc_en_q),
        .threshold (dpc_threshold_q),
        .win       (dpc_win),
        .out       (dpc_beat)
    );

    window_3x3 u_blur_window (.pixel_clk(pixel_clk), .reset(reset), .in(dpc_beat), .win(blur_win));

    gauss_blur u_blur
    (
        .pixel_clk (pixel_clk),
        .reset     (reset),
        .enable    (blur_en_q),
        .win       (blur_win),
        .out       (blur_beat)
    );

    // debug tap, value 3 falls back to the blur output
    always_ff @(posedge pixel_clk)
    begin
        if (reset)
            out <= '0;
        else
        begin
            case (debug_sel_q)
                isp_pkg::tap_raw:   out <= in_q;
                isp_pkg::tap_dpc:   out <= dpc_beat;
                isp_pkg::tap_gauss: out <= blur_beat;
                default:            out <= blur_beat;
            endcase
        end
    end

endmodule

/* bench/isp_pipeline_tb.sv */
`timescale 1ns/1ps

module isp_pipeline_tb;

    localparam int img_height    = 8;
    localparam int reset_cycles  = 8;
    localparam int settle_cycles = 4;
    localparam int num_frames    = 7;
    // one idle cycle per line plus settle and drain
    localparam int frame_cycles  = img_height * (isp_pkg::img_width + 1) + 16;
    localparam int stim_cycles   = reset_cycles + settle_cycles + num_frames * frame_cycles;
    localparam int cycle_limit   = stim_cycles * 3 / 2 + 200;

    typedef isp_pkg::pixel_t frame_t [img_height][isp_pkg::img_width];

    logic                 pixel_clk;
    logic                 reset;
    isp_pkg::pixel_beat_t in_beat;
    logic                 dpc_en;
    isp_pkg::pixel_t      dpc_threshold;
    logic                 blur_en;
    isp_pkg::tap_t        debug_sel;
    isp_pkg::pixel_beat_t out_beat;

    frame_t src_img;
    frame_t dpc_img;
    frame_t blur_img;
    isp_pkg::pixel_beat_t expected_q [$];
    isp_pkg::pixel_beat_t exp_beat;
    logic [15:0] lfsr_state;
    string test_name;
    int data_errors = 0;
    int flag_errors = 0;
    int beat_errors = 0;
    int cycle_count = 0;

    isp_pipeline u_dut
    (
        .pixel_clk     (pixel_clk),
        .reset         (reset),
        .in            (in_beat),
        .dpc_en        (dpc_en),
        .dpc_threshold (dpc_threshold),
        .blur_en       (blur_en),
        .debug_sel     (debug_sel),
        .out           (out_beat)
    );

    initial
    begin
        pixel_clk = 1'b0;
        forever #50 pixel_clk = ~pixel_clk;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic random_pixel(output isp_pkg::pixel_t value);
        value = '0;
        for (int b = 0; b < isp_pkg::pix_width; b++)
        begin
            value = {value[isp_pkg::pix_width-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // expected pixel at (r, c) from the window centered one row and column back
    function automatic isp_pkg::pixel_t window_rule(input frame_t img, input int r, input int c,
                                                    input bit blur, input bit enable,
                                                    input int thr);
        int w [3][3];
        int sum;
        bit hot;
        bit cold;
        if (r < 2 || c < 2)
            return img[r][c];
        for (int i = 0; i < 3; i++)
            for (int j = 0; j < 3; j++)
                w[i][j] = int'(img[r-2+i][c-2+j]);
        if (blur)
        begin
            if (!enable)
                return isp_pkg::pixel_t'(w[1][1]);
            sum = 4 * w[1][1] + 2 * (w[0][1] + w[1][0] + w[1][2] + w[2][1])
                + w[0][0] + w[0][2] + w[2][0] + w[2][2];
            return isp_pkg::pixel_t'(sum / 16);
        end
        hot  = 1'b1;
        cold = 1'b1;
        for (int i = 0; i < 3; i++)
            for (int j = 0; j < 3; j++)
                if (i != 1 || j != 1)
                begin
                    if (w[1][1] <= w[i][j] + thr)
                        hot = 1'b0;
                    if (w[i][j] <= w[1][1] + thr)
                        cold = 1'b0;
                end
        if (enable && (hot || cold))
            return isp_pkg::pixel_t'((w[0][1] + w[2][1] + w[1][0] + w[1][2]) / 4);
        return isp_pkg::pixel_t'(w[1][1]);
    endfunction

    task automatic build_frame(input bit inject, input bit dpc_on, input int thr,
                               input bit blur_on);
        for (int r = 0; r < img_height; r++)
            for (int c = 0; c < isp_pkg::img_width; c++)
                random_pixel(src_img[r][c]);
        if (inject)
        begin
            // interior stuck pixels
            src_img[2][4]  = 10'd1023;
            src_img[4][9]  = 10'd0;
            src_img[5][3]  = 10'd1023;
            src_img[6][13] = 10'd0;
        end
        for (int r = 0; r < img_height; r++)
            for (int c = 0; c < isp_pkg::img_width; c++)
                dpc_img[r][c] = window_rule(src_img, r, c, 1'b0, dpc_on, thr);
        for (int r = 0; r < img_height; r++)
            for (int c = 0; c < isp_pkg::img_width; c++)
                blur_img[r][c] = window_rule(dpc_img, r, c, 1'b1, blur_on, 0);
    endtask

    task automatic queue_expected(input isp_pkg::tap_t sel);
        isp_pkg::pixel_beat_t beat;
        for (int r = 0; r < img_height; r++)
            for (int c = 0; c < isp_pkg::img_width; c++)
            begin
                beat.valid = 1'b1;
                beat.sof   = (r == 0) && (c == 0);
                beat.eol   = (c == isp_pkg::img_width - 1);
                case (sel)
                    isp_pkg::tap_raw: beat.data = src_img[r][c];
                    isp_pkg::tap_dpc: beat.data = dpc_img[r][c];
                    default:          beat.data = blur_img[r][c];
                endcase
                expected_q.push_back(beat);
            end
    endtask

    task automatic run_frame(input string name, input isp_pkg::tap_t sel, input bit dpc_on,
                             input int thr, input bit blur_on, input bit inject);
        @(posedge pixel_clk);
        test_name = name;
        debug_sel     <= sel;
        dpc_en        <= dpc_on;
        dpc_threshold <= isp_pkg::pixel_t'(thr);
        blur_en       <= blur_on;
        repeat (settle_cycles) @(posedge pixel_clk);
        build_frame(inject, dpc_on, thr, blur_on);
        queue_expected(sel);
        for (int r = 0; r < img_height; r++)
        begin
            for (int c = 0; c < isp_pkg::img_width; c++)
            begin
                @(posedge pixel_clk);
                in_beat.valid <= 1'b1;
                in_beat.sof   <= (r == 0) && (c == 0);
                in_beat.eol   <= (c == isp_pkg::img_width - 1);
                in_beat.data  <= src_img[r][c];
            end
            // idle cycle after every line
            @(posedge pixel_clk);
            in_beat.valid <= 1'b0;
            in_beat.sof   <= 1'b0;
            in_beat.eol   <= 1'b0;
        end
        while (expected_q.size() != 0)
            @(posedge pixel_clk);
        repeat (settle_cycles) @(posedge pixel_clk);
    endtask

    task automatic report_counts;
        $display("errors: data %0d, flags %0d, beats %0d", data_errors, flag_errors,
                 beat_errors);
    endtask

    ////////////////////////////////////////////////////////////
    // output comparison and timeout
    ////////////////////////////////////////////////////////////

    always @(negedge pixel_clk)
    begin
        if (!reset && out_beat.valid)
        begin
            if (expected_q.size() == 0)
            begin
                beat_errors++;
                $display("%s: output beat arrived with no matching input beat", test_name);
            end
            else
            begin
                exp_beat = expected_q.pop_front();
                if (out_beat.data !== exp_beat.data)
                begin
                    data_errors++;
                    $display("error %s: data expected %0d actual %0d", test_name,
                             exp_beat.data, out_beat.data);
                end
                if (out_beat.sof !== exp_beat.sof)
                begin
                    flag_errors++;
                    $display("error %s: sof expected %0b actual %0b", test_name,
                             exp_beat.sof, out_beat.sof);
                end
                if (out_beat.eol !== exp_beat.eol)
                begin
                    flag_errors++;
                    $display("error %s: eol expected %0b actual %0b", test_name,
                             exp_beat.eol, out_beat.eol);
                end
            end
        end
    end

    always @(posedge pixel_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout after %0d cycles, %0d expected beats never came out",
                     cycle_count, expected_q.size());
            report_counts();
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        in_beat       = '0;
        dpc_en        = 1'b0;
        dpc_threshold = '0;
        blur_en       = 1'b0;
        debug_sel     = isp_pkg::tap_gauss;
        reset         = 1'b1;
        lfsr_state    = 16'd11982;
        test_name     = "after_reset";
        repeat (reset_cycles) @(posedge pixel_clk);
        reset <= 1'b0;

        // no beat may appear before the first input
        repeat (settle_cycles)
        begin
            @(negedge pixel_clk);
            if (out_beat.valid !== 1'b0)
            begin
                beat_errors++;
                $display("out.valid is not low after reset with no input");
            end
        end

        run_frame("raw_tap", isp_pkg::tap_raw, 1'b1, 40, 1'b1, 1'b1);
        run_frame("dpc_disabled", isp_pkg::tap_dpc, 1'b0, 40, 1'b1, 1'b1);
        run_frame("dpc_enabled", isp_pkg::tap_dpc, 1'b1, 40, 1'b1, 1'b1);
        run_frame("gauss_full", isp_pkg::tap_gauss, 1'b1, 40, 1'b1, 1'b1);
        run_frame("gauss_blur_off", isp_pkg::tap_gauss, 1'b1, 40, 1'b0, 1'b1);
        run_frame("tap_three", 2'd3, 1'b1, 40, 1'b1, 1'b1);
        run_frame("gauss_clean", isp_pkg::tap_gauss, 1'b1, 40, 1'b1, 1'b0);

        report_counts();
        if (data_errors + flag_errors + beat_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* files.f */
design/isp_pkg.sv
design/window_3x3.sv
design/dead_pixel_corrector.sv
design/gauss_blur.sv
design/isp_pipeline.sv
bench/isp_pipeline_tb.sv

/* Makefile */
# Verilator build and run for the ISP pipeline testbench

VERILATOR ?= verilator
TOP       ?= isp_pipeline_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Test failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
